/* Makefile */
# Verilator build and run of the alignment testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f nw_align.f \
		--top-module nw_align_tb -Mdir obj_dir
	./obj_dir/Vnw_align_tb | tee $(LOG)
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* nw_align.f */
rtl/nw_pkg.sv
rtl/score_ram.sv
rtl/neighbor_fetch.sv
rtl/cell_score.sv
rtl/fill_ctrl.sv
rtl/nw_align.sv
sim/nw_checker.sv
sim/nw_align_tb.sv

/* rtl/cell_score.sv */
`timescale 1ns/1ns

module cell_score
    import nw_pkg::*;
#(
    parameter int score_w        = 9,
    parameter int match_score    = 2,
    parameter int mismatch_score = -1,
    parameter int gap_score      = -2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      nb_valid,
    input  logic signed [score_w-1:0] diag,
    input  logic signed [score_w-1:0] up,
    input  logic signed [score_w-1:0] left,
    input  logic [base_w-1:0]         base_a,   // Row base
    input  logic [base_w-1:0]         base_b,   // Column base
    output logic signed [score_w-1:0] cell_out,
    output logic                      cell_valid
);
    localparam logic signed [score_w-1:0] match_v    = score_w'(match_score);
    localparam logic signed [score_w-1:0] mismatch_v = score_w'(mismatch_score);
    localparam logic signed [score_w-1:0] gap_v      = score_w'(gap_score);

    logic signed [score_w-1:0] sub;      // Substitution score
    logic signed [score_w-1:0] sum_diag;
    logic signed [score_w-1:0] sum_up;
    logic signed [score_w-1:0] sum_left;
    logic signed [score_w-1:0] best;

    assign sub      = (base_a == base_b) ? match_v : mismatch_v;
    assign sum_diag = diag + sub;     // Align a[i] with b[j]
    assign sum_up   = up + gap_v;     // Gap in b
    assign sum_left = left + gap_v;   // Gap in a

    // Max of three, diagonal wins ties
    always_comb begin
        best = sum_diag;
        if (sum_up > best)   best = sum_up;
        if (sum_left > best) best = sum_left;
    end

    always_ff @(posedge clk) begin
        if (nb_valid) cell_out <= best;   // Held until next cell
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) cell_valid <= 1'b0;
        else     cell_valid <= nb_valid;
    end

endmodule

/* rtl/fill_ctrl.sv */
`timescale 1ns/1ns

module fill_ctrl
    import nw_pkg::*;
#(
    parameter int seq_len   = 4,
    parameter int score_w   = 9,
    parameter int gap_score = -2
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic [seq_len*base_w-1:0]              seq_a,
    input  logic [seq_len*base_w-1:0]              seq_b,
    output logic                                   busy,
    output logic                                   done,
    output logic signed [score_w-1:0]              score,
    output logic                                   rd_en,
    output logic [$clog2((seq_len+1)*(seq_len+1))-1:0] rd_addr,
    output tag_t                                   rd_tag,
    output logic                                   en_read,
    output logic                                   wr_en,
    output logic [$clog2((seq_len+1)*(seq_len+1))-1:0] wr_addr,
    output logic signed [score_w-1:0]              wr_data,
    output logic [base_w-1:0]                      base_a,
    output logic [base_w-1:0]                      base_b,
    input  logic                                   cell_valid,
    input  logic signed [score_w-1:0]              cell_out
);
    localparam int addr_w = $clog2((seq_len + 1) * (seq_len + 1));
    localparam int idx_w  = $clog2(seq_len + 1);
    localparam int bidx_w = $clog2(2 * seq_len + 1);
    localparam int cols   = seq_len + 1;   // Row stride

    fill_state_t state;
    tag_t rd_slot;                             // Next neighbor to read
    logic [seq_len*base_w-1:0] seq_a_q, seq_b_q;
    logic [bidx_w-1:0] bidx;                   // Border write index
    logic [idx_w-1:0] ri, ci;                  // Interior cell index from zero
    logic signed [score_w-1:0] res_q;          // Cell result to store
    logic [addr_w-1:0] cur_addr;
    logic [addr_w-1:0] border_addr;
    logic signed [score_w-1:0] border_data;
    logic last_cell;

    // Border value is index times gap
    function automatic logic signed [score_w-1:0] gap_mul(input int idx);
        int v;
        v = idx * gap_score;
        return v[score_w-1:0];
    endfunction

    assign cur_addr  = addr_w'((ri + 1) * cols + ci + 1);
    assign last_cell = (ri == idx_w'(seq_len - 1)) && (ci == idx_w'(seq_len - 1));

    // First seq_len+1 writes cover row zero and the rest column zero
    always_comb begin
        if (bidx <= bidx_w'(seq_len)) begin
            border_addr = addr_w'(bidx);
            border_data = gap_mul(int'(bidx));
        end else begin
            border_addr = addr_w'((bidx - seq_len) * cols);
            border_data = gap_mul(int'(bidx) - seq_len);
        end
    end

    always_comb begin
        case (rd_slot)
            slot_diag: rd_addr = cur_addr - addr_w'(cols + 1);
            slot_up:   rd_addr = cur_addr - addr_w'(cols);
            default:   rd_addr = cur_addr - addr_w'(1);
        endcase
    end

    assign rd_en   = (state == s_read);
    assign rd_tag  = rd_slot;
    assign en_read = (state == s_read) || (state == s_wait);
    assign wr_en   = (state == s_border) || (state == s_write);
    assign wr_addr = (state == s_write) ? cur_addr : border_addr;
    assign wr_data = (state == s_write) ? res_q : border_data;
    assign base_a  = seq_a_q[ri*base_w +: base_w];   // Row follows seq_a
    assign base_b  = seq_b_q[ci*base_w +: base_w];   // Column follows seq_b
    assign busy    = (state != s_idle);
    assign done    = (state == s_done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= s_idle;
            rd_slot <= slot_diag;
            bidx    <= '0;
            ri      <= '0;
            ci      <= '0;
            score   <= '0;
        end else begin
            case (state)
                s_idle: if (start) begin   // Start while busy never gets here
                    bidx  <= '0;
                    state <= s_border;
                end
                s_border: begin
                    if (bidx == bidx_w'(2 * seq_len)) begin
                        ri      <= '0;
                        ci      <= '0;
                        rd_slot <= slot_diag;
                        state   <= s_read;
                    end else begin
                        bidx <= bidx + 1'b1;
                    end
                end
                s_read: begin
                    case (rd_slot)
                        slot_diag: rd_slot <= slot_up;
                        slot_up:   rd_slot <= slot_left;
                        default: begin
                            rd_slot <= slot_diag;
                            state   <= s_wait;
                        end
                    endcase
                end
                s_wait: if (cell_valid) state <= s_write;
                s_write: begin
                    if (last_cell) begin
                        score <= res_q;    // Bottom-right cell
                        state <= s_done;
                    end else begin
                        if (ci == idx_w'(seq_len - 1)) begin
                            ci <= '0;
                            ri <= ri + 1'b1;
                        end else begin
                            ci <= ci + 1'b1;
                        end
                        state <= s_read;
                    end
                end
                default: state <= s_idle;   // s_done lasts one cycle
            endcase
        end
    end

    // Sequences captured on start, cell result on cell_valid
    always_ff @(posedge clk) begin
        if (state == s_idle && start) begin
            seq_a_q <= seq_a;
            seq_b_q <= seq_b;
        end
        if (state == s_wait && cell_valid) res_q <= cell_out;
    end

    // Border writes land only in row zero or column zero
    a_border_addr: assert property (@(posedge clk) disable iff (rst)
        (wr_en && state == s_border) |-> ((wr_addr < cols) || (wr_addr % cols == 0)));

    // Cell pipeline only answers a fetch this controller started
    a_cell_in_wait: assert property (@(posedge clk) disable iff (rst)
        cell_valid |-> (state == s_wait));

endmodule

/* rtl/neighbor_fetch.sv */
`timescale 1ns/1ns

module neighbor_fetch
    import nw_pkg::*;
#(
    parameter int score_w = 9
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      en_read,     // High while controller fetches
    input  tag_t                      count,       // Slot of the arriving word
    input  logic signed [score_w-1:0] ram_data,
    input  logic                      valid,
    output logic signed [score_w-1:0] diag,
    output logic signed [score_w-1:0] up,
    output logic signed [score_w-1:0] left,
    output logic                      nb_valid
);
    logic signed [score_w-1:0] buffer [3];    // One word per neighbor slot
    logic ready;                              // Left word landed last cycle

    // Capture each tagged word
    always_ff @(posedge clk) begin
        if (en_read && valid) buffer[count] <= ram_data;
    end

    // Ready pulses once, after the last slot is in the buffer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready <= 1'b0;
        end else begin
            ready <= en_read && valid && (count == slot_left);
        end
    end

    // Buffer is stable by now, so read it a cycle after ready
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            diag     <= '0;
            up       <= '0;
            left     <= '0;
            nb_valid <= 1'b0;
        end else if (ready) begin
            diag     <= buffer[slot_diag];
            up       <= buffer[slot_up];
            left     <= buffer[slot_left];
            nb_valid <= 1'b1;
        end else begin
            diag     <= '0;   // Zero outside the valid cycle
            up       <= '0;
            left     <= '0;
            nb_valid <= 1'b0;
        end
    end

    // Only three slots exist
    a_count_in_range: assert property (@(posedge clk) disable iff (rst)
        valid |-> (count inside {slot_diag, slot_up, slot_left}));

    // One neighbor set per cell, never back to back
    a_nb_single: assert property (@(posedge clk) disable iff (rst)
        nb_valid |=> !nb_valid);

endmodule

/* rtl/nw_align.sv */
`timescale 1ns/1ns

module nw_align
    import nw_pkg::*;
#(
    parameter int seq_len        = 4,
    parameter int score_w        = 9,
    parameter int match_score    = 2,
    parameter int mismatch_score = -1,
    parameter int gap_score      = -2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [seq_len*base_w-1:0] seq_a,
    input  logic [seq_len*base_w-1:0] seq_b,
    output logic                      busy,
    output logic                      done,
    output logic signed [score_w-1:0] score
);
    localparam int addr_w = $clog2((seq_len + 1) * (seq_len + 1));

    logic rd_en, rd_valid, wr_en, en_read;
    logic [addr_w-1:0] rd_addr, wr_addr;
    tag_t rd_tag, rd_tag_q;
    logic signed [score_w-1:0] rd_data, wr_data;
    logic signed [score_w-1:0] diag, up, left;
    logic nb_valid, cell_valid;
    logic signed [score_w-1:0] cell_out;
    logic [base_w-1:0] base_a, base_b;

    fill_ctrl #(.seq_len(seq_len), .score_w(score_w), .gap_score(gap_score)) ctrl_i (
        .clk, .rst, .start, .seq_a, .seq_b, .busy, .done, .score,
        .rd_en, .rd_addr, .rd_tag, .en_read, .wr_en, .wr_addr, .wr_data,
        .base_a, .base_b, .cell_valid, .cell_out
    );

    score_ram #(.seq_len(seq_len), .score_w(score_w)) ram_i (
        .clk, .rst, .rd_en, .rd_addr, .rd_tag, .rd_data, .rd_tag_q, .rd_valid,
        .wr_en, .wr_addr, .wr_data
    );

    // Tag from memory selects the buffer slot
    neighbor_fetch #(.score_w(score_w)) fetch_i (
        .clk, .rst, .en_read, .count(rd_tag_q), .ram_data(rd_data), .valid(rd_valid),
        .diag, .up, .left, .nb_valid
    );

    cell_score #(
        .score_w(score_w), .match_score(match_score),
        .mismatch_score(mismatch_score), .gap_score(gap_score)
    ) cell_i (
        .clk, .rst, .nb_valid, .diag, .up, .left, .base_a, .base_b,
        .cell_out, .cell_valid
    );

endmodule

/* rtl/nw_pkg.sv */
package nw_pkg;

    // Two bits per base, A=0 C=1 G=2 T=3
    localparam int base_w = 2;

    // Which neighbor a returning score word belongs to
    typedef enum logic [1:0] {
        slot_diag = 2'd0,   // Cell (i-1, j-1)
        slot_up   = 2'd1,   // Cell (i-1, j)
        slot_left = 2'd2    // Cell (i, j-1)
    } tag_t;

    // Matrix fill controller states
    typedef enum logic [2:0] {
        s_idle,     // Waiting for start
        s_border,   // Row zero and column zero
        s_read,     // Three neighbor reads
        s_wait,     // Waiting on the cell result
        s_write,    // Store cell, step to next
        s_done      // Final score out, one cycle
    } fill_state_t;

endpackage

/* rtl/score_ram.sv */
`timescale 1ns/1ns

module score_ram
    import nw_pkg::*;
#(
    parameter int seq_len = 4,
    parameter int score_w = 9
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   rd_en,
    input  logic [$clog2((seq_len+1)*(seq_len+1))-1:0] rd_addr,
    input  tag_t                                   rd_tag,
    output logic signed [score_w-1:0]              rd_data,
    output tag_t                                   rd_tag_q,
    output logic                                   rd_valid,
    input  logic                                   wr_en,
    input  logic [$clog2((seq_len+1)*(seq_len+1))-1:0] wr_addr,
    input  logic signed [score_w-1:0]              wr_data
);
    localparam int depth = (seq_len + 1) * (seq_len + 1);   // Full matrix, row-major

    logic signed [score_w-1:0] mem [depth];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
    end

    // Read data and tag travel together, one cycle late
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data  <= mem[rd_addr];
            rd_tag_q <= rd_tag;     // Lets the fetch block sort the word
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) rd_valid <= 1'b0;
        else     rd_valid <= rd_en;
    end

    // No read-during-write on one cell, old/new data would be ambiguous
    a_no_rw_collision: assert property (@(posedge clk) disable iff (rst)
        !(rd_en && wr_en && (rd_addr == wr_addr)));

endmodule

/* sim/nw_align_tb.sv */
`timescale 1ns/1ns

module nw_align_tb
    import nw_pkg::*;
();
    localparam int seq_len    = 4;
    localparam int score_w    = 9;
    localparam int seq_w      = seq_len * base_w;
    localparam int n_cases    = 8;     // Lines in the case file
    localparam int busy_case  = 2;     // Gets a second start while busy
    localparam int reset_case = 5;     // Preceded by a run cut short by reset
    localparam int max_wait   = 400;   // Cycles allowed per run

    logic clk;
    logic rst;
    logic start;
    logic [seq_w-1:0] seq_a;
    logic [seq_w-1:0] seq_b;
    logic busy;
    logic done;
    logic signed [score_w-1:0] score;
    logic exp_valid;
    logic [score_w-1:0] exp_score;
    int exp_case;
    logic report;
    int tb_errors;
    int err_cnt;

    nw_align #(.seq_len(seq_len), .score_w(score_w)) dut_i (
        .clk, .rst, .start, .seq_a, .seq_b, .busy, .done, .score
    );

    nw_checker #(.score_w(score_w)) chk_i (
        .clk, .rst, .busy, .done, .score, .exp_valid, .exp_score, .exp_case,
        .report, .tb_errors, .err_cnt
    );

    always #5 clk = ~clk;   // 10 ns period

    // One-cycle start, driven on the falling edge
    task automatic pulse_start(input logic [seq_w-1:0] a, input logic [seq_w-1:0] b,
                               input bit with_exp, input logic [score_w-1:0] e,
                               input int idx);
        @(negedge clk);
        seq_a     = a;
        seq_b     = b;
        start     = 1'b1;
        exp_valid = with_exp;   // Checker queues it on the same edge
        exp_score = e;
        exp_case  = idx;
        @(negedge clk);
        start     = 1'b0;
        exp_valid = 1'b0;
    endtask

    task automatic wait_done(input int idx, output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < max_wait) begin
            @(negedge clk);   // Done is stable mid-cycle
            if (done) ok = 1'b1;
            n++;
        end
        if (!ok) begin
            $display("case %0d: no done pulse within %0d cycles", idx, max_wait);
            tb_errors++;
        end
    endtask

    // Run partway into the cell loop, then reset
    task automatic abort_run(input logic [seq_w-1:0] a, input logic [seq_w-1:0] b);
        pulse_start(a, b, 1'b0, '0, -1);
        repeat (30) @(negedge clk);
        rst = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_case(input logic [seq_w-1:0] a, input logic [seq_w-1:0] b,
                            input logic [score_w-1:0] e, input int idx, output bit ok);
        if (idx == reset_case) abort_run(a, b);
        pulse_start(a, b, 1'b1, e, idx);
        if (idx == busy_case) begin
            repeat (20) @(negedge clk);
            pulse_start(~a, a, 1'b0, '0, idx);   // Must be ignored
        end
        wait_done(idx, ok);
    endtask

    initial begin
        int fd;
        int code;
        int n;
        int idx;
        bit ok;
        bit stop;
        string line;
        logic [31:0] a_v;
        logic [31:0] b_v;
        logic [31:0] e_v;

        clk       = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        seq_a     = '0;
        seq_b     = '0;
        exp_valid = 1'b0;
        exp_score = '0;
        exp_case  = 0;
        report    = 1'b0;
        tb_errors = 0;
        idx       = 0;
        stop      = 1'b0;

        repeat (5) @(negedge clk);
        rst = 1'b0;

        fd = $fopen("sim/nw_cases.txt", "r");
        if (fd == 0) begin
            $display("case file sim/nw_cases.txt could not be opened");
            tb_errors++;
            stop = 1'b1;
        end
        while (!stop) begin
            code = $fgets(line, fd);
            if (code == 0) begin
                stop = 1'b1;   // End of file
            end else if (line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h", a_v, b_v, e_v);
                if (n == 3) begin
                    run_case(a_v[seq_w-1:0], b_v[seq_w-1:0], e_v[score_w-1:0], idx, ok);
                    if (!ok) stop = 1'b1;   // DUT stuck, skip the rest
                    idx++;
                end
            end
        end
        if (fd != 0) $fclose(fd);
        if (idx != n_cases) begin
            $display("only %0d of %0d cases were run", idx, n_cases);
            tb_errors++;
        end

        repeat (3) @(negedge clk);
        report = 1'b1;   // Checker prints the counts
        #1;
        if (err_cnt == 0 && tb_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* sim/nw_cases.txt */
# seq_a seq_b expected, all hex; base i at bits 2i+1:2i with A=0 C=1 G=2 T=3
# expected is the 9-bit two's complement score of the bottom-right cell
e4 e4 008   ACGT vs ACGT, identical
00 55 1fc   AAAA vs CCCC, all mismatch
e4 39 002   ACGT vs CGTA, shifted by one
e4 24 005   ACGT vs ACGA, one mismatch
00 00 008   AAAA vs AAAA
ff aa 1fc   TTTT vs GGGG
39 e4 002   CGTA vs ACGT, shifted the other way
e4 1b 1fc   ACGT vs TGCA, reversed

/* sim/nw_checker.sv */
`timescale 1ns/1ns

module nw_checker #(
    parameter int score_w = 9
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      busy,
    input  logic                      done,
    input  logic signed [score_w-1:0] score,
    input  logic                      exp_valid,   // Start with an expected score
    input  logic [score_w-1:0]        exp_score,
    input  int                        exp_case,
    input  logic                      report,      // Print the closing counts
    input  int                        tb_errors,   // Timeouts and such from the stimulus side
    output int                        err_cnt
);
    logic [score_w-1:0] exp_q [$];    // Expected scores, oldest first
    int case_q [$];
    logic [score_w-1:0] held = '0;    // Score seen at the last done
    logic held_valid = 1'b0;
    logic done_q = 1'b0;
    logic rst_q = 1'b1;
    logic [score_w-1:0] cur_exp = '0;
    int cur_case = 0;
    int pass_cnt = 0;
    int fails = 0;

    assign err_cnt = fails;

    // Sample on the rising edge, DUT outputs still hold last cycle's values
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();   // Reset aborts any run in flight
            case_q.delete();
            held_valid = 1'b0;
            done_q     = 1'b0;
        end else begin
            if (rst_q) begin
                // First edge after reset release
                if (busy !== 1'b0 || done !== 1'b0 || score !== '0) begin
                    $display("ERROR after reset: busy=0x%h done=0x%h score=0x%h, expected 0x0",
                             busy, done, score);
                    fails++;
                end else begin
                    $display("reset: busy, done and score cleared");
                    pass_cnt++;
                end
            end
            if (done_q && (busy !== 1'b0 || done !== 1'b0)) begin
                $display("ERROR after done: busy=0x%h done=0x%h, expected 0x0", busy, done);
                fails++;
            end
            if (held_valid && !busy && score !== held) begin
                $display("ERROR idle: score expected 0x%h, got 0x%h", held, score);
                fails++;
            end
            if (done) begin
                if (exp_q.size() == 0) begin
                    $display("done pulse arrived with no case waiting for it");
                    fails++;
                end else begin
                    cur_exp  = exp_q.pop_front();
                    cur_case = case_q.pop_front();
                    if (score !== cur_exp) begin
                        $display("ERROR case %0d: score expected 0x%h, got 0x%h",
                                 cur_case, cur_exp, score);
                        fails++;
                    end else begin
                        $display("case %0d: score 0x%h as expected", cur_case, score);
                        pass_cnt++;
                    end
                end
                held       = score;   // Must hold while idle
                held_valid = 1'b1;
            end
            if (exp_valid) begin
                exp_q.push_back(exp_score);
                case_q.push_back(exp_case);
            end
            done_q = done;
        end
        rst_q = rst;
    end

    always @(posedge report) begin
        $display("counts: %0d passed, %0d failed", pass_cnt, fails + tb_errors);
    end

endmodule
